/* design/fbw_pkg.sv */
// sizes, burst state enum and bus structs of the frame-buffer write engine
package fbw_pkg;

	// ----------------------------------------
	// memory layout
	// ----------------------------------------
	localparam int DATA_W      = 64;  // one image word, 8 bytes
	localparam int DEPTH_W     = 3;   // frame pointer and frame depth
	localparam int BURST_IDX_W = 16;  // burst index inside one frame
	localparam int BURST_WORDS = 64;  // max words per burst
	localparam int BLEN_W      = 6;   // burst length field, words minus one
	localparam int ZERO_BITS   = 9;   // 64 words x 8 bytes = 512 bytes per burst
	localparam int ADDR_W      = 30;  // byte address on the memory port

	// reserved burst slot for the trailer, near the end of the frame area
	localparam logic [BURST_IDX_W-1:0] TRAILER_BURST = {{(BURST_IDX_W-1){1'b1}}, 1'b0};

	// ----------------------------------------
	// buffering and flow control
	// ----------------------------------------
	localparam int FIFO_DEPTH   = 512; // front FIFO entries
	localparam int CMD_CREDITS  = 4;   // command slots on the memory side
	localparam int DATA_CREDITS = 64;  // data word slots on the memory side
	localparam int DEPTH_RESET  = 2;   // frame depth out of reset

	// burst machine
	typedef enum logic [2:0] {
		IDLE,     // no frame data to move
		FILL,     // words from FIFO to memory port
		CMD_WAIT, // burst closed, waiting for a command credit
		CMD,      // command pulse
		NEXT      // step burst index
	} burst_state_e;

	// front FIFO entry
	typedef struct packed {
		logic              trailer; // word is the frame trailer
		logic [DATA_W-1:0] data;
	} fifo_word_t;

	// memory write command, one per burst
	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;    // {zeros, frame ptr, burst idx, 9 zeros}
		logic [BLEN_W-1:0] blen;    // word count minus one
	} mem_cmd_t;

	// memory write data
	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
	} mem_wr_t;

	// frame events out of the decoder
	typedef struct packed {
		logic armed; // stream armed by a frame start
		logic start; // one-cycle frame start pulse
		logic fval;  // registered frame valid
	} frame_evt_t;

endpackage

/* design/front_fifo.sv */
// synchronous first-word-fall-through FIFO of image words with trailer bit
`timescale 1ns/1ns

module front_fifo
(
	input  logic                clk,
	input  logic                reset,
	input  logic                i_push,
	input  fbw_pkg::fifo_word_t i_word,
	input  logic                i_pop,
	output fbw_pkg::fifo_word_t o_head,
	output logic                o_not_empty,
	input  logic                i_flush
);
	import fbw_pkg::*;

	fifo_word_t mem [FIFO_DEPTH]; // entry storage

	// one extra wrap bit so a completely filled buffer is not seen as empty
	logic [$clog2(FIFO_DEPTH):0] wr_ptr;
	logic [$clog2(FIFO_DEPTH):0] rd_ptr;

	// ----------------------------------------
	// storage
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (i_push)
		begin
			mem[wr_ptr[$clog2(FIFO_DEPTH)-1:0]] <= i_word;
		end
	end

	// ----------------------------------------
	// pointers
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset || i_flush) // flush drops all entries at once
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop && o_not_empty) // pop on empty ignored
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// head shows without a pop
	assign o_head      = mem[rd_ptr[$clog2(FIFO_DEPTH)-1:0]];
	assign o_not_empty = (wr_ptr != rd_ptr);

endmodule

/* design/frame_decode.sv */
// frame edge detect, stream arming, frame depth latch and FIFO push
`timescale 1ns/1ns

module frame_decode
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_fval,
	input  logic                        i_dval,
	input  logic                        i_trailer,
	input  logic [fbw_pkg::DATA_W-1:0]  i_data,
	input  logic                        i_stream_en,
	input  logic [fbw_pkg::DEPTH_W-1:0] i_frame_depth,
	output logic                        o_push,
	output fbw_pkg::fifo_word_t         o_word,
	output logic                        o_flush,
	output fbw_pkg::frame_evt_t         o_evt,
	output logic [fbw_pkg::DEPTH_W-1:0] o_frame_depth
);
	import fbw_pkg::*;

	logic fval_q;    // frame valid, one cycle late
	logic fval_rise; // first high sample of frame valid
	logic armed;     // writing enabled for the current frame
	logic start;     // frame start pulse
	logic accept;    // word taken this cycle

	assign fval_rise = i_fval & ~fval_q;

	// word counts as soon as the frame that arms the stream begins
	assign accept = i_fval & i_dval & i_stream_en & (armed | fval_rise);

	// ----------------------------------------
	// frame edge and arming
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fval_q <= 1'b0;
			start  <= 1'b0;
			armed  <= 1'b0;
		end
		else
		begin
			fval_q <= i_fval;
			start  <= fval_rise;
			if (!i_stream_en)
				armed <= 1'b0; // stop drops it at once
			else if (fval_rise)
				armed <= 1'b1; // only a frame start arms
		end
	end

	// push one cycle after the accepted word
	always_ff @(posedge clk)
	begin
		if (reset)
			o_push <= 1'b0;
		else
			o_push <= accept;
	end

	always_ff @(posedge clk)
	begin
		o_word <= '{trailer: i_trailer, data: i_data};
	end

	// depth may change only while stopped
	always_ff @(posedge clk)
	begin
		if (reset)
			o_frame_depth <= DEPTH_W'(DEPTH_RESET);
		else if (!i_stream_en)
			o_frame_depth <= i_frame_depth;
	end

	assign o_flush = ~armed; // FIFO held empty while disarmed
	assign o_evt   = '{armed: armed, start: start, fval: fval_q};

endmodule

/* design/burst_execute.sv */
// burst FSM, command and data credit counters, word count and command issue
`timescale 1ns/1ns

module burst_execute
(
	input  logic                        clk,
	input  logic                        reset,
	input  fbw_pkg::fifo_word_t         i_head,
	input  logic                        i_not_empty,
	output logic                        o_pop,
	input  fbw_pkg::frame_evt_t         i_evt,
	input  logic [fbw_pkg::DEPTH_W-1:0] i_frame_ptr,
	input  logic                        i_ptr_ready,
	input  logic                        i_cmd_credit,
	input  logic                        i_data_credit,
	output fbw_pkg::mem_cmd_t           o_cmd,
	output fbw_pkg::mem_wr_t            o_wr
);
	import fbw_pkg::*;

	typedef logic [$clog2(BURST_WORDS+1)-1:0]  cnt_t;   // 0 .. 64 words
	typedef logic [$clog2(CMD_CREDITS+1)-1:0]  ccred_t;
	typedef logic [$clog2(DATA_CREDITS+1)-1:0] dcred_t;

	burst_state_e           state;
	burst_state_e           state_nxt;
	logic [BURST_IDX_W-1:0] burst_idx;  // burst number in frame
	logic [BURST_IDX_W-1:0] cmd_idx;    // burst slot the command goes to
	cnt_t                   word_cnt;   // words sent in this burst
	logic                   trl_burst;  // current burst is the trailer alone
	ccred_t                 cmd_cred;
	dcred_t                 data_cred;
	logic                   pop;        // word leaves FIFO for the port
	logic                   cmd_fire;
	logic                   burst_full;
	logic                   frame_done; // frame over and FIFO drained
	logic                   wr_valid;
	logic [DATA_W-1:0]      wr_data;

	assign burst_full = (word_cnt == cnt_t'(BURST_WORDS));
	assign frame_done = ~i_evt.fval & ~i_not_empty;
	assign cmd_fire   = (state == CMD);

	// trailer only leaves as the first word of an empty burst
	assign pop = (state == FILL) & i_evt.armed & i_not_empty & (data_cred != '0)
		& ~burst_full & (~i_head.trailer | (word_cnt == '0));
	assign o_pop = pop;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (i_ptr_ready && i_not_empty) // pointer settled, data waiting
					state_nxt = FILL;
			FILL:
				if (burst_full || (i_not_empty && i_head.trailer && word_cnt != '0))
					state_nxt = CMD_WAIT;                             // close before trailer
				else if (pop && i_head.trailer)
					state_nxt = CMD_WAIT;                             // one-word trailer burst
				else if (frame_done)
					state_nxt = (word_cnt != '0) ? CMD_WAIT : IDLE;   // short last burst
			CMD_WAIT:
				if (cmd_cred != '0)
					state_nxt = CMD;
			CMD:
				state_nxt = NEXT;
			NEXT:
				state_nxt = frame_done ? IDLE : FILL;
			default:
				state_nxt = IDLE;
		endcase
		if (!i_evt.armed)
			state_nxt = IDLE; // stream stopped
	end

	// ----------------------------------------
	// state, burst index, word count
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= IDLE;
			burst_idx <= '0;
			word_cnt  <= '0;
			trl_burst <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (state == IDLE) // between frames or disarmed
			begin
				burst_idx <= '0;
				word_cnt  <= '0;
				trl_burst <= 1'b0;
			end
			else if (state == NEXT)
			begin
				if (!trl_burst)
					burst_idx <= burst_idx + 1'b1;
				word_cnt  <= '0;
				trl_burst <= 1'b0;
			end
			else if (pop)
			begin
				word_cnt <= word_cnt + 1'b1;
				if (i_head.trailer)
					trl_burst <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// credit counters, capped at reset value
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cmd_cred  <= ccred_t'(CMD_CREDITS);
			data_cred <= dcred_t'(DATA_CREDITS);
		end
		else
		begin
			case ({cmd_fire, i_cmd_credit})
				2'b10: cmd_cred <= cmd_cred - 1'b1;
				2'b01: if (cmd_cred != ccred_t'(CMD_CREDITS))
					cmd_cred <= cmd_cred + 1'b1;
				default: cmd_cred <= cmd_cred; // none or both
			endcase
			case ({pop, i_data_credit})
				2'b10: data_cred <= data_cred - 1'b1;
				2'b01: if (data_cred != dcred_t'(DATA_CREDITS))
					data_cred <= data_cred + 1'b1;
				default: data_cred <= data_cred;
			endcase
		end
	end

	// write port, one cycle after pop
	always_ff @(posedge clk)
	begin
		if (reset)
			wr_valid <= 1'b0;
		else
			wr_valid <= pop;
	end

	always_ff @(posedge clk)
	begin
		if (pop)
			wr_data <= i_head.data;
	end

	assign o_wr    = '{valid: wr_valid, data: wr_data};
	assign cmd_idx = trl_burst ? TRAILER_BURST : burst_idx;

	// command after the last word of the burst is on the port
	assign o_cmd = '{
		valid: cmd_fire,
		addr:  {{(ADDR_W-DEPTH_W-BURST_IDX_W-ZERO_BITS){1'b0}}, i_frame_ptr, cmd_idx,
			{ZERO_BITS{1'b0}}},
		blen:  BLEN_W'(word_cnt - 1'b1)
	};

endmodule

/* design/frame_ptr_result.sv */
// write frame pointer pipeline with reader skip and pointer-changing flag
`timescale 1ns/1ns

module frame_ptr_result
(
	input  logic                        clk,
	input  logic                        reset,
	input  fbw_pkg::frame_evt_t         i_evt,
	input  logic [fbw_pkg::DEPTH_W-1:0] i_rd_frame_ptr,
	input  logic [fbw_pkg::DEPTH_W-1:0] i_frame_depth,
	output logic [fbw_pkg::DEPTH_W-1:0] o_wr_frame_ptr,
	output logic                        o_ptr_changing,
	output logic                        o_ptr_ready
);
	import fbw_pkg::*;

	logic               go;         // armed frame start
	logic [1:0]         pipe_v;     // stage 2 and stage 3 valid
	logic               hit;        // ptr+1 lands on the reader
	logic [DEPTH_W:0]   inc;        // 1 or 2
	logic               first_done; // first frame after arming seen
	logic [DEPTH_W:0]   one_sum;
	logic [DEPTH_W:0]   inc_sum;

	// sum of pointer and step, folded back into 0 .. depth-1
	function automatic logic [DEPTH_W-1:0] wrap_ptr(input logic [DEPTH_W:0] sum,
		input logic [DEPTH_W-1:0] depth);
		logic [DEPTH_W:0] diff;
		diff = sum - {1'b0, depth};
		if (sum >= {1'b0, depth})
			return diff[DEPTH_W-1:0];
		return sum[DEPTH_W-1:0];
	endfunction

	assign go      = i_evt.start & i_evt.armed;
	assign one_sum = {1'b0, o_wr_frame_ptr} + 1'b1;
	assign inc_sum = {1'b0, o_wr_frame_ptr} + inc;

	// ----------------------------------------
	// stage 1 and 2 data
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (go)
			hit <= (wrap_ptr(one_sum, i_frame_depth) == i_rd_frame_ptr); // reader next?
		if (pipe_v[0])
			inc <= hit ? (DEPTH_W+1)'(2) : (DEPTH_W+1)'(1);             // jump over it
	end

	// ----------------------------------------
	// stage 3, flag and pointer
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset || !i_evt.armed) // stop returns to frame 0
		begin
			pipe_v         <= '0;
			o_ptr_changing <= 1'b0;
			first_done     <= 1'b0;
			o_wr_frame_ptr <= '0;
		end
		else
		begin
			pipe_v         <= {pipe_v[0], go};
			o_ptr_changing <= go | pipe_v[0] | pipe_v[1]; // start+1 .. start+3
			if (pipe_v[1])
			begin
				first_done <= 1'b1;
				if (first_done) // first frame stays on 0
					o_wr_frame_ptr <= wrap_ptr(inc_sum, i_frame_depth);
			end
		end
	end

	// writes wait for the new pointer
	assign o_ptr_ready = ~(go | o_ptr_changing);

endmodule

/* design/frame_writer_top.sv */
// top of the frame-buffer write engine, decode, FIFO, burst engine, pointer
`timescale 1ns/1ns

module frame_writer_top
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_fval,
	input  logic                        i_dval,
	input  logic                        i_trailer,
	input  logic [fbw_pkg::DATA_W-1:0]  i_data,
	input  logic                        i_stream_en,
	input  logic [fbw_pkg::DEPTH_W-1:0] i_frame_depth,
	input  logic [fbw_pkg::DEPTH_W-1:0] i_rd_frame_ptr,
	input  logic                        i_cmd_credit,
	input  logic                        i_data_credit,
	output fbw_pkg::mem_cmd_t           o_cmd,
	output fbw_pkg::mem_wr_t            o_wr,
	output logic [fbw_pkg::DEPTH_W-1:0] o_wr_frame_ptr,
	output logic                        o_ptr_changing,
	output logic [fbw_pkg::DEPTH_W-1:0] o_frame_depth
);
	import fbw_pkg::*;

	// ----------------------------------------
	// internal links
	// ----------------------------------------
	logic       push;
	fifo_word_t push_word;
	logic       flush;      // FIFO cleared while disarmed
	frame_evt_t evt;
	fifo_word_t head;
	logic       not_empty;
	logic       pop;
	logic       ptr_ready;  // low while the pointer moves

	frame_decode u_decode
	(
		.clk           (clk),
		.reset         (reset),
		.i_fval        (i_fval),
		.i_dval        (i_dval),
		.i_trailer     (i_trailer),
		.i_data        (i_data),
		.i_stream_en   (i_stream_en),
		.i_frame_depth (i_frame_depth),
		.o_push        (push),
		.o_word        (push_word),
		.o_flush       (flush),
		.o_evt         (evt),
		.o_frame_depth (o_frame_depth)
	);

	front_fifo u_fifo
	(
		.clk         (clk),
		.reset       (reset),
		.i_push      (push),
		.i_word      (push_word),
		.i_pop       (pop),
		.o_head      (head),
		.o_not_empty (not_empty),
		.i_flush     (flush)
	);

	burst_execute u_exec
	(
		.clk           (clk),
		.reset         (reset),
		.i_head        (head),
		.i_not_empty   (not_empty),
		.o_pop         (pop),
		.i_evt         (evt),
		.i_frame_ptr   (o_wr_frame_ptr),
		.i_ptr_ready   (ptr_ready),
		.i_cmd_credit  (i_cmd_credit),
		.i_data_credit (i_data_credit),
		.o_cmd         (o_cmd),
		.o_wr          (o_wr)
	);

	frame_ptr_result u_result
	(
		.clk            (clk),
		.reset          (reset),
		.i_evt          (evt),
		.i_rd_frame_ptr (i_rd_frame_ptr),
		.i_frame_depth  (o_frame_depth),
		.o_wr_frame_ptr (o_wr_frame_ptr),
		.o_ptr_changing (o_ptr_changing),
		.o_ptr_ready    (ptr_ready)
	);

endmodule

/* verif/frame_writer_checker.sv */
// bound assertions on credit use, burst length and reset state of the burst engine
`timescale 1ns/1ns

module frame_writer_checker
(
	input logic                clk,
	input logic                reset,
	input logic                i_cmd_credit,
	input logic                i_data_credit,
	input fbw_pkg::mem_cmd_t   o_cmd,
	input fbw_pkg::mem_wr_t    o_wr
);
	import fbw_pkg::*;

	int words_out;   // words on the port, credit not back yet
	int cmds_out;    // commands issued, credit not back yet
	int burst_words; // words since the last command

	// ----------------------------------------
	// port-side counts
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			words_out   <= 0;
			cmds_out    <= 0;
			burst_words <= 0;
		end
		else
		begin
			words_out <= words_out + int'(o_wr.valid) - int'(i_data_credit);
			cmds_out  <= cmds_out + int'(o_cmd.valid) - int'(i_cmd_credit);
			if (o_cmd.valid)
				burst_words <= 0; // next burst counts from here
			else if (o_wr.valid)
				burst_words <= burst_words + 1;
		end
	end

	// ----------------------------------------
	// credit rules
	// ----------------------------------------
	a_data_credit: assert property (@(posedge clk) disable iff (reset)
		words_out <= DATA_CREDITS)
		else $error("word sent with zero data credit");

	a_cmd_credit: assert property (@(posedge clk) disable iff (reset)
		cmds_out <= CMD_CREDITS)
		else $error("command sent with zero command credit");

	// burst length matches the words sent and stays in range
	a_blen: assert property (@(posedge clk) disable iff (reset)
		o_cmd.valid |-> ((burst_words <= BURST_WORDS)
			&& (int'(o_cmd.blen) == burst_words - 1)))
		else $error("burst length wrong or too large");

	// outputs quiet once reset is sampled
	a_reset_quiet: assert property (@(posedge clk)
		reset |=> (!o_cmd.valid && !o_wr.valid))
		else $error("valid output under reset");

endmodule

bind burst_execute frame_writer_checker u_chk
(
	.clk           (clk),
	.reset         (reset),
	.i_cmd_credit  (i_cmd_credit),
	.i_data_credit (i_data_credit),
	.o_cmd         (o_cmd),
	.o_wr          (o_wr)
);

/* verif/tb_frame_writer.sv */
// testbench of the frame writer: clock, reset, credit model, directed tests
`timescale 1ns/1ns

module tb_frame_writer;
	import fbw_pkg::*;

	logic                clk;
	logic                reset;
	logic                i_fval;
	logic                i_dval;
	logic                i_trailer;
	logic [DATA_W-1:0]   i_data;
	logic                i_stream_en;
	logic [DEPTH_W-1:0]  i_frame_depth;
	logic [DEPTH_W-1:0]  i_rd_frame_ptr;
	logic                i_cmd_credit;
	logic                i_data_credit;
	mem_cmd_t            o_cmd;
	mem_wr_t             o_wr;
	logic [DEPTH_W-1:0]  o_wr_frame_ptr;
	logic                o_ptr_changing;
	logic [DEPTH_W-1:0]  o_frame_depth;

	logic [31:0]       lfsr;
	int                cyc;         // cycle count for credit due times
	bit                hold;        // withhold all credit returns
	logic [DATA_W-1:0] wr_q[$];     // words seen on o_wr
	mem_cmd_t          cmd_q[$];    // commands seen on o_cmd
	int                data_due[$];
	int                cmd_due[$];
	int                run_q[$];    // lengths of o_ptr_changing pulses
	int                run_len;
	logic [DATA_W-1:0] exp_words[$];
	int                exp_ptr;     // reference frame pointer
	int                depth_m;
	int                rd_m;
	bit                fresh;       // next frame is the first after arming

	frame_writer_top uut
	(
		.clk            (clk),
		.reset          (reset),
		.i_fval         (i_fval),
		.i_dval         (i_dval),
		.i_trailer      (i_trailer),
		.i_data         (i_data),
		.i_stream_en    (i_stream_en),
		.i_frame_depth  (i_frame_depth),
		.i_rd_frame_ptr (i_rd_frame_ptr),
		.i_cmd_credit   (i_cmd_credit),
		.i_data_credit  (i_data_credit),
		.o_cmd          (o_cmd),
		.o_wr           (o_wr),
		.o_wr_frame_ptr (o_wr_frame_ptr),
		.o_ptr_changing (o_ptr_changing),
		.o_frame_depth  (o_frame_depth)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], next_bit()};
		return v;
	endfunction

	// ----------------------------------------
	// memory side model
	// ----------------------------------------
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (o_wr.valid)
			begin
				wr_q.push_back(o_wr.data);
				data_due.push_back(cyc + int'(rand_bits(3))); // 0..7 cycles
			end
			if (o_cmd.valid)
			begin
				cmd_q.push_back(o_cmd);
				cmd_due.push_back(cyc + int'(rand_bits(3)));
			end
			if (o_ptr_changing)
				run_len++;
			else if (run_len != 0)
			begin
				run_q.push_back(run_len);
				run_len = 0;
			end
		end
	end

	// one credit pulse of each kind per cycle at most
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (reset)
		begin
			i_data_credit <= 1'b0;
			i_cmd_credit  <= 1'b0;
		end
		else
		begin
			i_data_credit <= 1'b0;
			i_cmd_credit  <= 1'b0;
			if (!hold && data_due.size() > 0 && data_due[0] <= cyc)
			begin
				void'(data_due.pop_front());
				i_data_credit <= 1'b1;
			end
			if (!hold && cmd_due.size() > 0 && cmd_due[0] <= cyc)
			begin
				void'(cmd_due.pop_front());
				i_cmd_credit <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
			fail_run("value check failed");
		end
	endtask

	// reference pointer step at an armed frame start
	task automatic advance_ptr();
		int nxt;
		if (fresh)
			fresh = 1'b0; // first frame keeps pointer 0
		else
		begin
			nxt = (exp_ptr + 1) % depth_m;
			if (nxt == rd_m)
				nxt = (exp_ptr + 2) % depth_m; // skip the reader
			exp_ptr = nxt;
		end
	endtask

	task automatic send_frame(input int n, input bit trl, input bit keep);
		logic [DATA_W-1:0] w;
		for (int i = 0; i < n + trl; i++)
		begin
			w = rand_bits(DATA_W);
			@(posedge clk);
			i_fval    <= 1'b1;
			i_dval    <= 1'b1;
			i_trailer <= (trl && i == n);
			i_data    <= w;
			if (keep)
				exp_words.push_back(w);
		end
		@(posedge clk);
		i_fval    <= 1'b0;
		i_dval    <= 1'b0;
		i_trailer <= 1'b0;
	endtask

	task automatic expect_frame(input int n, input bit trl);
		int       nc;
		int       t;
		int       idx;
		int       len;
		mem_cmd_t c;
		nc = (n + BURST_WORDS - 1) / BURST_WORDS + trl;
		t  = 0;
		while (wr_q.size() < n + trl || cmd_q.size() < nc)
		begin
			@(posedge clk);
			t++;
			if (t > 5000)
				fail_run("timeout waiting for the frame to reach the memory port");
		end
		repeat (4) @(posedge clk); // room for stray extra output
		check_eq("o_wr count", wr_q.size(), n + trl);
		check_eq("o_cmd count", cmd_q.size(), nc);
		for (int i = 0; i < n + trl; i++)
			check_eq("o_wr.data", wr_q.pop_front(), exp_words.pop_front());
		for (int k = 0; k < nc; k++)
		begin
			c = cmd_q.pop_front();
			if (trl && k == nc - 1)
			begin
				idx = TRAILER_BURST;
				len = 1;
			end
			else
			begin
				idx = k;
				len = (n - k * BURST_WORDS > BURST_WORDS) ? BURST_WORDS : n - k * BURST_WORDS;
			end
			check_eq("o_cmd.addr", c.addr,
				(64'(exp_ptr) << (BURST_IDX_W + ZERO_BITS)) | (64'(idx) << ZERO_BITS));
			check_eq("o_cmd.blen", c.blen, len - 1);
		end
	endtask

	task automatic run_frame(input int n, input bit trl);
		advance_ptr();
		send_frame(n, trl, 1'b1);
		expect_frame(n, trl);
	endtask

	task automatic set_stream(input bit en);
		@(posedge clk);
		i_stream_en <= en;
		if (!en)
		begin
			exp_ptr = 0; // stop returns to frame 0
			fresh   = 1'b1;
		end
		repeat (2) @(posedge clk);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_burst_packing();
		run_frame(150, 1'b0);
	endtask

	task automatic test_trailer();
		run_frame(10, 1'b1);
	endtask

	task automatic test_ptr_skip();
		int seq [6] = '{0, 1, 3, 0, 1, 3};
		set_stream(1'b0);
		@(posedge clk);
		i_frame_depth  <= 3'd4;
		i_rd_frame_ptr <= 3'd2;
		depth_m = 4;
		rd_m    = 2;
		set_stream(1'b1);
		run_q.delete();
		for (int i = 0; i < 6; i++)
		begin
			run_frame(8, 1'b0);
			check_eq("o_wr_frame_ptr", o_wr_frame_ptr, seq[i]);
		end
		check_eq("o_ptr_changing pulses", run_q.size(), 6);
		foreach (run_q[i])
			check_eq("o_ptr_changing width", run_q[i], 3);
	endtask

	task automatic test_stream_ctrl();
		@(posedge clk);
		i_frame_depth <= 3'd5; // ignored while enabled
		repeat (3) @(negedge clk);
		check_eq("o_frame_depth", o_frame_depth, 4);
		set_stream(1'b0);
		@(negedge clk);
		check_eq("o_frame_depth", o_frame_depth, 5);
		depth_m = 5;
		send_frame(20, 1'b0, 1'b0);
		repeat (30) @(posedge clk);
		check_eq("o_wr count", wr_q.size(), 0);
		check_eq("o_cmd count", cmd_q.size(), 0);
		set_stream(1'b1);
		run_frame(12, 1'b0);
		check_eq("o_wr_frame_ptr", o_wr_frame_ptr, 0);
		run_frame(12, 1'b0);
	endtask

	task automatic test_backpressure();
		int t;
		int nw;
		int nc;
		t = 0;
		while (data_due.size() != 0 || cmd_due.size() != 0)
		begin
			@(posedge clk);
			t++;
			if (t > 100)
				fail_run("timeout waiting for earlier credits to return");
		end
		@(posedge clk); // last credit pulse reaches the counters
		hold = 1'b1;
		advance_ptr();
		send_frame(200, 1'b0, 1'b1);
		t = 0;
		while (wr_q.size() < DATA_CREDITS || cmd_q.size() < 1)
		begin
			@(posedge clk);
			t++;
			if (t > 1000)
				fail_run("timeout waiting for the first credit window of words");
		end
		nw = wr_q.size();
		nc = cmd_q.size();
		repeat (50) @(posedge clk);
		check_eq("o_wr count while held", wr_q.size(), nw);
		check_eq("o_cmd count while held", cmd_q.size(), nc);
		check_eq("words sent on reset credit", nw, DATA_CREDITS);
		check_eq("commands sent on reset credit", nc, 1); // first full burst
		hold = 1'b0;
		expect_frame(200, 1'b0);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		reset          = 1'b1;
		i_fval         = 1'b0;
		i_dval         = 1'b0;
		i_trailer      = 1'b0;
		i_data         = '0;
		i_stream_en    = 1'b1;
		i_frame_depth  = 3'(DEPTH_RESET);
		i_rd_frame_ptr = '0;
		i_cmd_credit   = 1'b0;
		i_data_credit  = 1'b0;
		lfsr           = 32'h13d6;
		cyc            = 0;
		hold           = 1'b0;
		run_len        = 0;
		exp_ptr        = 0;
		fresh          = 1'b1;
		depth_m        = DEPTH_RESET;
		rd_m           = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_eq("o_cmd.valid", o_cmd.valid, 0);
		check_eq("o_wr.valid", o_wr.valid, 0);
		check_eq("o_ptr_changing", o_ptr_changing, 0);
		check_eq("o_wr_frame_ptr", o_wr_frame_ptr, 0);
		check_eq("o_frame_depth", o_frame_depth, DEPTH_RESET);
		repeat (3) @(posedge clk);
		test_burst_packing();
		test_trailer();
		test_ptr_skip();
		test_stream_ctrl();
		test_backpressure();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* tb.f */
design/fbw_pkg.sv
design/front_fifo.sv
design/frame_decode.sv
design/burst_execute.sv
design/frame_ptr_result.sv
design/frame_writer_top.sv
verif/frame_writer_checker.sv
verif/tb_frame_writer.sv
